// ==== logic/csi2_pkg.sv ====
package csi2_pkg;

    typedef logic [9:0]  pixel_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_count_t;
    typedef logic [15:0] frame_num_t;
    typedef logic [5:0]  data_type_t;
    typedef logic [5:0]  ecc_t;
    typedef logic [15:0] crc_t;

    localparam int          line_pixels     = 16;
    localparam word_count_t line_word_count = word_count_t'(line_pixels * 10 / 8);

    localparam data_type_t dt_frame_start = 6'h00;
    localparam data_type_t dt_frame_end   = 6'h01;
    localparam data_type_t dt_raw10       = 6'h2B;

    localparam int   queue_depth   = 16;
    localparam int   lp_gap_cycles = 4;
    localparam crc_t crc_seed      = 16'hFFFF;
    localparam crc_t crc_poly      = 16'h8408;   // 0x1021 reflected

    typedef enum logic [1:0] {
        frame_start,
        frame_end,
        pixel_group,
        line_end
    } entry_kind_e;

    typedef struct packed {
        entry_kind_e kind;
        logic [39:0] group;   // byte 0 in bits 7:0
    } queue_entry_t;

    typedef struct packed {
        byte_t data;
        logic  valid;
        logic  last;
    } tx_byte_t;

    // hamming parity over {wc_hi, wc_lo, data id}
    function automatic ecc_t ecc_calc(input logic [23:0] hdr);
        ecc_t ecc;
        ecc[0] = ^(hdr & 24'hF12CB7);
        ecc[1] = ^(hdr & 24'hF2555B);
        ecc[2] = ^(hdr & 24'h749A6D);
        ecc[3] = ^(hdr & 24'hB8E38E);
        ecc[4] = ^(hdr & 24'hDF03F0);
        ecc[5] = ^(hdr & 24'hEFFC00);
        return ecc;
    endfunction

    // one byte into the crc, lsb first
    function automatic crc_t crc_byte_step(input crc_t crc, input byte_t data);
        crc_t c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// ==== logic/raw10_byte_packer.sv ====
`timescale 1ns/1ps
module raw10_byte_packer (
    input  logic                   clock_camera_byte,
    input  logic                   reset_camera_byte_n,
    input  logic                   pixel_valid_i,
    input  logic                   frame_valid_i,
    input  logic                   line_valid_i,
    input  csi2_pkg::pixel_t       pixel_i,
    output logic                   push_o,
    output csi2_pkg::queue_entry_t entry_o
);

    logic                  frame_valid_q;
    logic                  line_valid_q;
    logic [1:0]            slot_q;
    logic [39:0]           group_q;
    logic [39:0]           group_next;
    logic                  fs_pend_q;
    logic                  le_pend_q;
    logic                  fe_pend_q;
    logic                  pix_take;
    logic                  group_push;
    logic                  fs_want;
    logic                  le_want;
    logic                  fe_want;
    csi2_pkg::entry_kind_e push_kind;

    assign pix_take   = pixel_valid_i && line_valid_i;
    assign group_push = (pix_take && slot_q == 2'd3)
                     || (!line_valid_i && line_valid_q && slot_q != 2'd0);   // short line pad

    // edges wait while a group goes out first
    assign fs_want = fs_pend_q || (frame_valid_i && !frame_valid_q);
    assign le_want = le_pend_q || (!line_valid_i && line_valid_q);
    assign fe_want = fe_pend_q || (!frame_valid_i && frame_valid_q);

    always_comb begin
        group_next = group_q;
        if (pix_take) begin
            group_next[slot_q*8 +: 8]      = pixel_i[9:2];   // msbs in bytes 0..3
            group_next[32 + slot_q*2 +: 2] = pixel_i[1:0];   // lsbs packed in byte 4
        end
    end

    always_comb begin
        push_kind = csi2_pkg::pixel_group;
        if (!group_push) begin
            if (fs_want) begin
                push_kind = csi2_pkg::frame_start;
            end else if (le_want) begin
                push_kind = csi2_pkg::line_end;
            end else begin
                push_kind = csi2_pkg::frame_end;
            end
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            frame_valid_q <= 1'b0;
            line_valid_q  <= 1'b0;
            push_o        <= 1'b0;
            fs_pend_q     <= 1'b0;
            le_pend_q     <= 1'b0;
            fe_pend_q     <= 1'b0;
            slot_q        <= 2'd0;
            group_q       <= '0;
        end else begin
            frame_valid_q <= frame_valid_i;
            line_valid_q  <= line_valid_i;
            push_o        <= group_push || fs_want || le_want || fe_want;
            fs_pend_q     <= fs_want && group_push;
            le_pend_q     <= le_want && (group_push || fs_want);
            fe_pend_q     <= fe_want && (group_push || fs_want || le_want);
            if (group_push) begin
                group_q <= '0;   // zero pad for next group
                slot_q  <= 2'd0;
            end else begin
                group_q <= group_next;
                if (pix_take) begin
                    slot_q <= slot_q + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        entry_o.kind  <= push_kind;
        entry_o.group <= group_push ? group_next : '0;
    end

endmodule

// ==== logic/event_queue.sv ====
`timescale 1ns/1ps
module event_queue (
    input  logic                   clock_camera_byte,
    input  logic                   reset_camera_byte_n,
    input  logic                   push_i,
    input  csi2_pkg::queue_entry_t entry_i,
    input  logic                   pop_i,
    output logic                   not_empty_o,
    output csi2_pkg::queue_entry_t head_o,
    output logic                   line_ready_o,
    output logic                   overflow_o
);

    typedef logic [$clog2(csi2_pkg::queue_depth)-1:0] ptr_t;
    typedef logic [$clog2(csi2_pkg::queue_depth):0]   cnt_t;

    csi2_pkg::queue_entry_t mem_q [csi2_pkg::queue_depth];
    ptr_t                   wr_ptr_q;
    ptr_t                   rd_ptr_q;
    cnt_t                   count_q;
    cnt_t                   line_cnt_q;   // line_end entries held
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    assign full         = count_q == cnt_t'(csi2_pkg::queue_depth);
    assign not_empty_o  = count_q != '0;
    assign do_push      = push_i && !full;
    assign do_pop       = pop_i && not_empty_o;
    assign head_o       = mem_q[rd_ptr_q];
    assign line_ready_o = line_cnt_q != '0
                       || (not_empty_o && (head_o.kind == csi2_pkg::frame_start
                                        || head_o.kind == csi2_pkg::frame_end));

    always_ff @(posedge clock_camera_byte) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            line_cnt_q <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + ptr_t'(1);
            if (do_pop)  rd_ptr_q <= rd_ptr_q + ptr_t'(1);
            count_q    <= count_q + cnt_t'(do_push) - cnt_t'(do_pop);
            line_cnt_q <= line_cnt_q
                        + cnt_t'(do_push && entry_i.kind == csi2_pkg::line_end)
                        - cnt_t'(do_pop && head_o.kind == csi2_pkg::line_end);
            if (push_i && full) begin
                overflow_o <= 1'b1;   // sticky, entry dropped
            end
        end
    end

endmodule

// ==== logic/csi2_packet_builder.sv ====
`timescale 1ns/1ps
module csi2_packet_builder (
    input  logic                   clock_camera_byte,
    input  logic                   reset_camera_byte_n,
    input  logic                   not_empty_i,
    input  logic                   line_ready_i,
    input  csi2_pkg::queue_entry_t head_i,
    output logic                   pop_o,
    output logic                   pkt_pending_o,
    input  logic                   grant_i,
    output csi2_pkg::tx_byte_t     tx_o
);

    typedef enum logic [2:0] {
        idle,
        wait_grant,
        header,
        payload,
        crc
    } state_e;

    state_e                  state_q;
    logic [31:0]             hdr_q;        // di, wc lo, wc hi, ecc
    logic                    is_long_q;
    csi2_pkg::word_count_t   byte_cnt_q;
    logic [2:0]              grp_idx_q;    // byte within group
    csi2_pkg::crc_t          crc_q;
    csi2_pkg::frame_num_t    frame_num_q;
    csi2_pkg::data_type_t    dt;
    csi2_pkg::word_count_t   wc;
    logic [23:0]             hdr_bits;
    logic                    head_is_group;
    logic                    start_pkt;
    csi2_pkg::byte_t         pay_byte;

    assign head_is_group = not_empty_i && head_i.kind == csi2_pkg::pixel_group;
    assign start_pkt     = state_q == idle && not_empty_i && line_ready_i
                        && head_i.kind != csi2_pkg::line_end;
    assign pkt_pending_o = state_q == wait_grant;
    assign pay_byte      = head_is_group ? head_i.group[grp_idx_q*8 +: 8] : '0;
    assign hdr_bits      = {wc, 2'b00, dt};   // virtual channel 0

    always_comb begin
        unique case (head_i.kind)
            csi2_pkg::frame_start: begin
                dt = csi2_pkg::dt_frame_start;
                wc = frame_num_q + 16'd1;   // number this frame will carry
            end
            csi2_pkg::frame_end: begin
                dt = csi2_pkg::dt_frame_end;
                wc = frame_num_q;
            end
            default: begin
                dt = csi2_pkg::dt_raw10;
                wc = csi2_pkg::line_word_count;
            end
        endcase
    end

    always_comb begin
        pop_o = 1'b0;
        case (state_q)
            idle:    pop_o = not_empty_i && head_i.kind != csi2_pkg::pixel_group;
            payload: pop_o = head_is_group && grp_idx_q == 3'd4;
            crc:     pop_o = byte_cnt_q == '0 && not_empty_i
                          && head_i.kind == csi2_pkg::line_end;
            default: pop_o = 1'b0;
        endcase
    end

    always_comb begin
        tx_o = '0;
        case (state_q)
            header: begin
                tx_o.data  = hdr_q[byte_cnt_q[1:0]*8 +: 8];
                tx_o.valid = 1'b1;
                tx_o.last  = !is_long_q && byte_cnt_q == 16'd3;
            end
            payload: begin
                tx_o.data  = pay_byte;
                tx_o.valid = 1'b1;
            end
            crc: begin
                tx_o.data  = byte_cnt_q[0] ? crc_q[15:8] : crc_q[7:0];
                tx_o.valid = 1'b1;
                tx_o.last  = byte_cnt_q[0];
            end
            default: tx_o = '0;
        endcase
    end

    always_ff @(posedge clock_camera_byte) begin
        if (start_pkt) begin
            hdr_q <= {2'b00, csi2_pkg::ecc_calc(hdr_bits), hdr_bits};
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            state_q     <= idle;
            is_long_q   <= 1'b0;
            byte_cnt_q  <= '0;
            grp_idx_q   <= 3'd0;
            crc_q       <= csi2_pkg::crc_seed;
            frame_num_q <= '0;
        end else begin
            case (state_q)
                idle: if (start_pkt) begin
                    is_long_q <= head_is_group;
                    if (head_i.kind == csi2_pkg::frame_start) begin
                        frame_num_q <= frame_num_q + 16'd1;
                    end
                    state_q <= wait_grant;
                end
                wait_grant: if (grant_i) begin
                    byte_cnt_q <= '0;
                    state_q    <= header;
                end
                header: begin
                    byte_cnt_q <= byte_cnt_q + 16'd1;
                    crc_q      <= csi2_pkg::crc_seed;
                    if (byte_cnt_q == 16'd3) begin
                        byte_cnt_q <= '0;
                        grp_idx_q  <= 3'd0;
                        state_q    <= is_long_q ? payload : idle;
                    end
                end
                payload: begin
                    crc_q      <= csi2_pkg::crc_byte_step(crc_q, pay_byte);
                    grp_idx_q  <= (grp_idx_q == 3'd4) ? 3'd0 : grp_idx_q + 3'd1;
                    byte_cnt_q <= byte_cnt_q + 16'd1;
                    if (byte_cnt_q == csi2_pkg::line_word_count - 16'd1) begin
                        byte_cnt_q <= '0;
                        state_q    <= crc;
                    end
                end
                crc: begin
                    byte_cnt_q <= byte_cnt_q + 16'd1;
                    if (byte_cnt_q[0]) begin
                        state_q <= idle;
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

endmodule

// ==== logic/hs_lane_ctrl.sv ====
`timescale 1ns/1ps
module hs_lane_ctrl (
    input  logic               clock_camera_byte,
    input  logic               reset_camera_byte_n,
    input  logic               pkt_pending_i,
    output logic               grant_o,
    input  csi2_pkg::tx_byte_t tx_i,
    output logic               hs_req_o,
    input  logic               hs_rdy_i,
    output csi2_pkg::byte_t    byte_o,
    output logic               byte_valid_o
);

    // four-phase handshake states
    typedef enum logic [2:0] {
        lp_idle,
        request,
        burst,
        release_wait,
        gap
    } state_e;

    typedef logic [$clog2(csi2_pkg::lp_gap_cycles + 1)-1:0] gap_cnt_t;

    state_e   state_q;
    gap_cnt_t gap_cnt_q;
    logic     last_q;   // last byte now on byte_o

    assign grant_o  = state_q == request && hs_rdy_i;
    assign hs_req_o = state_q == request || state_q == burst;

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            state_q      <= lp_idle;
            gap_cnt_q    <= '0;
            byte_valid_o <= 1'b0;
            last_q       <= 1'b0;
        end else begin
            byte_valid_o <= tx_i.valid && state_q == burst;
            last_q       <= tx_i.valid && tx_i.last && state_q == burst;
            case (state_q)
                lp_idle:      if (pkt_pending_i) state_q <= request;
                request:      if (hs_rdy_i) state_q <= burst;
                burst:        if (last_q) state_q <= release_wait;   // drop req after last
                release_wait: if (!hs_rdy_i) begin
                    gap_cnt_q <= '0;
                    state_q   <= gap;
                end
                gap: begin
                    gap_cnt_q <= gap_cnt_q + gap_cnt_t'(1);
                    if (gap_cnt_q == gap_cnt_t'(csi2_pkg::lp_gap_cycles - 1)) begin
                        state_q <= lp_idle;
                    end
                end
                default: state_q <= lp_idle;
            endcase
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        byte_o <= tx_i.data;
    end

endmodule

// ==== logic/csi2_tx_top.sv ====
`timescale 1ns/1ps
module csi2_tx_top (
    input  logic             clock_camera_byte,
    input  logic             reset_camera_byte_n,
    input  logic             pixel_valid_i,
    input  logic             frame_valid_i,
    input  logic             line_valid_i,
    input  csi2_pkg::pixel_t pixel_i,
    output logic             hs_req_o,
    input  logic             hs_rdy_i,
    output csi2_pkg::byte_t  byte_o,
    output logic             byte_valid_o,
    output logic             overflow_o
);

    logic                   push;
    csi2_pkg::queue_entry_t entry;
    logic                   not_empty;
    csi2_pkg::queue_entry_t head;
    logic                   line_ready;
    logic                   pop;
    logic                   pkt_pending;
    logic                   grant;
    csi2_pkg::tx_byte_t     tx;

    raw10_byte_packer raw10_byte_packer_i (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .pixel_valid_i       (pixel_valid_i),
        .frame_valid_i       (frame_valid_i),
        .line_valid_i        (line_valid_i),
        .pixel_i             (pixel_i),
        .push_o              (push),
        .entry_o             (entry)
    );

    event_queue event_queue_i (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .push_i              (push),
        .entry_i             (entry),
        .pop_i               (pop),
        .not_empty_o         (not_empty),
        .head_o              (head),
        .line_ready_o        (line_ready),
        .overflow_o          (overflow_o)
    );

    csi2_packet_builder csi2_packet_builder_i (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .not_empty_i         (not_empty),
        .line_ready_i        (line_ready),
        .head_i              (head),
        .pop_o               (pop),
        .pkt_pending_o       (pkt_pending),
        .grant_i             (grant),
        .tx_o                (tx)
    );

    hs_lane_ctrl hs_lane_ctrl_i (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .pkt_pending_i       (pkt_pending),
        .grant_o             (grant),
        .tx_i                (tx),
        .hs_req_o            (hs_req_o),
        .hs_rdy_i            (hs_rdy_i),
        .byte_o              (byte_o),
        .byte_valid_o        (byte_valid_o)
    );

endmodule

// ==== sim/csi2_tx_sva.sv ====
`timescale 1ns/1ps
module csi2_tx_sva (
    input logic clock_camera_byte,
    input logic reset_camera_byte_n,
    input logic hs_req_o,
    input logic hs_rdy_i,
    input logic byte_valid_o,
    input logic overflow_o
);

    int fail_count = 0;

    // request holds for the whole burst
    assert property (@(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        byte_valid_o |-> hs_req_o)
        else begin
            fail_count++;
            $error("byte sent without request");
        end

    // request only falls right after the last byte
    assert property (@(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        $fell(hs_req_o) |-> $past(byte_valid_o))
        else begin
            fail_count++;
            $error("request dropped before last byte");
        end

    assert property (@(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        byte_valid_o |-> hs_rdy_i)
        else begin
            fail_count++;
            $error("byte sent while phy not ready");
        end

    // minimum low-power gap after ready falls
    assert property (@(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        $fell(hs_rdy_i) |-> !hs_req_o [*csi2_pkg::lp_gap_cycles])
        else begin
            fail_count++;
            $error("request inside lp gap");
        end

    assert property (@(posedge clock_camera_byte) disable iff (!reset_camera_byte_n)
        !overflow_o)
        else begin
            fail_count++;
            $error("event queue overflow");
        end

endmodule

bind csi2_tx_top csi2_tx_sva csi2_tx_sva_i (.*);

// ==== sim/csi2_tx_tb.sv ====
`timescale 1ns/1ps
module csi2_tx_tb;

    localparam int wait_limit = 4000;

    logic                 clock_camera_byte;
    logic                 reset_camera_byte_n;
    logic                 pixel_valid_i;
    logic                 frame_valid_i;
    logic                 line_valid_i;
    csi2_pkg::pixel_t     pixel_i;
    logic                 hs_req_o;
    logic                 hs_rdy_i;
    csi2_pkg::byte_t      byte_o;
    logic                 byte_valid_o;
    logic                 overflow_o;

    int                   seed = 32'ha747;
    int                   errors = 0;
    int                   packets_seen = 0;
    logic                 slow_phy = 1'b0;
    csi2_pkg::frame_num_t frame_num = '0;
    csi2_pkg::pixel_t     line_pix [csi2_pkg::line_pixels];
    csi2_pkg::byte_t      exp_bytes [$];
    int                   exp_len [$];
    string                exp_name [$];
    csi2_pkg::byte_t      got_bytes [$];
    int                   got_len [$];
    csi2_pkg::byte_t      burst [$];
    csi2_pkg::byte_t      cur_pkt [$];

    csi2_tx_top csi2_tx_top_i (.*);

    initial begin
        clock_camera_byte = 1'b0;
        forever #4 clock_camera_byte = ~clock_camera_byte;
    end

    task automatic finish_run();
        errors += csi2_tx_top_i.csi2_tx_sva_i.fail_count;
        $display("packets checked %0d, errors %0d", packets_seen, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        finish_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    // ecc from the per-bit column codes of the csi-2 hamming table
    function automatic logic [5:0] ecc_ref(input logic [23:0] hdr);
        logic [5:0] col [24];
        logic [5:0] ecc;
        col = '{6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
                6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
                6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B};
        ecc = '0;
        for (int i = 0; i < 24; i++) begin
            if (hdr[i]) ecc ^= col[i];
        end
        return ecc;
    endfunction

    function automatic logic [15:0] crc_ref(input logic [15:0] crc, input logic [7:0] b);
        logic fb;
        for (int i = 0; i < 8; i++) begin
            fb  = crc[0] ^ b[i];
            crc = {1'b0, crc[15:1]};
            if (fb) crc ^= 16'h8408;
        end
        return crc;
    endfunction

    // kind 0 frame start, 1 frame end, 2 line from line_pix
    function automatic void build_packet(input int kind, input string name);
        logic [7:0]  p [$];
        logic [7:0]  grp [5];
        logic [5:0]  dt;
        logic [15:0] wc;
        logic [23:0] hdr;
        logic [15:0] crc;
        dt = (kind == 0) ? 6'h00 : (kind == 1) ? 6'h01 : 6'h2B;
        wc = (kind == 2) ? 16'(csi2_pkg::line_pixels * 10 / 8) : frame_num;
        hdr = {wc, 2'b00, dt};
        p.push_back(hdr[7:0]);
        p.push_back(hdr[15:8]);
        p.push_back(hdr[23:16]);
        p.push_back({2'b00, ecc_ref(hdr)});
        if (kind == 2) begin
            crc = 16'hFFFF;
            for (int g = 0; g < csi2_pkg::line_pixels / 4; g++) begin
                for (int k = 0; k < 4; k++) grp[k] = line_pix[4*g+k][9:2];
                grp[4] = {line_pix[4*g+3][1:0], line_pix[4*g+2][1:0],
                          line_pix[4*g+1][1:0], line_pix[4*g][1:0]};
                for (int k = 0; k < 5; k++) begin
                    p.push_back(grp[k]);
                    crc = crc_ref(crc, grp[k]);
                end
            end
            p.push_back(crc[7:0]);
            p.push_back(crc[15:8]);
        end
        foreach (p[i]) exp_bytes.push_back(p[i]);
        exp_len.push_back(p.size());
        exp_name.push_back(name);
    endfunction

    task automatic wait_req(input logic level, input string what);
        int n;
        n = 0;
        while (hs_req_o !== level) begin
            @(negedge clock_camera_byte);
            n++;
            if (n > wait_limit) timeout_fail(what);
        end
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (exp_len.size() != 0 || got_len.size() != 0 || hs_req_o) begin
            @(negedge clock_camera_byte);
            n++;
            if (n > wait_limit) timeout_fail(what);
        end
    endtask

    // mode 0 random pixels, mode 1 low bits rotate through every slot
    task automatic drive_frame(input int lines, input int mode, input string name);
        frame_valid_i = 1'b1;
        frame_num++;
        build_packet(0, $sformatf("%s fs %0d", name, frame_num));
        repeat (4) @(negedge clock_camera_byte);
        for (int l = 0; l < lines; l++) begin
            for (int i = 0; i < csi2_pkg::line_pixels; i++) begin
                if (mode == 0) line_pix[i] = 10'($random(seed));
                else line_pix[i] = {8'(8'h40 + i * 9), 2'(i + i / 4)};
            end
            build_packet(2, $sformatf("%s line %0d", name, l));
            for (int i = 0; i < csi2_pkg::line_pixels; i++) begin
                line_valid_i  = 1'b1;
                pixel_valid_i = 1'b1;
                pixel_i       = line_pix[i];
                @(negedge clock_camera_byte);
            end
            line_valid_i  = 1'b0;
            pixel_valid_i = 1'b0;
            pixel_i       = '0;
            repeat (44) @(negedge clock_camera_byte);   // line blanking
        end
        frame_valid_i = 1'b0;
        build_packet(1, $sformatf("%s fe %0d", name, frame_num));
        repeat (10) @(negedge clock_camera_byte);
    endtask

    task automatic compare_burst();
        string          name;
        int             n_exp;
        logic [7:0]     e;
        csi2_pkg::crc_t crc;
        name  = exp_name.pop_front();
        n_exp = exp_len.pop_front();
        check_value({name, " length"}, n_exp, cur_pkt.size());
        for (int i = 0; i < n_exp; i++) begin
            e = exp_bytes.pop_front();
            if (i < cur_pkt.size()) check_value($sformatf("%s byte %0d", name, i), e, cur_pkt[i]);
        end
        if (cur_pkt.size() >= 4) begin   // shared spec cross-check
            check_value({name, " ecc spec"},
                        csi2_pkg::ecc_calc({cur_pkt[2], cur_pkt[1], cur_pkt[0]}), cur_pkt[3]);
        end
        if (cur_pkt.size() == 26) begin
            crc = csi2_pkg::crc_seed;
            for (int i = 4; i < 24; i++) crc = csi2_pkg::crc_byte_step(crc, cur_pkt[i]);
            check_value({name, " crc spec"}, crc, {cur_pkt[25], cur_pkt[24]});
        end
    endtask

    // phy ready model
    initial begin
        int d;
        forever begin
            wait_req(1'b1, "hs request");
            d = slow_phy ? $unsigned($random(seed)) % 13 : $unsigned($random(seed)) % 7;
            repeat (d) @(negedge clock_camera_byte);
            hs_rdy_i = 1'b1;
            wait_req(1'b0, "hs request release");
            d = 1 + $unsigned($random(seed)) % 3;
            repeat (d) @(negedge clock_camera_byte);
            hs_rdy_i = 1'b0;
        end
    end

    // capture bursts
    initial begin
        forever begin
            @(negedge clock_camera_byte);
            if (byte_valid_o === 1'b1) begin
                burst.push_back(byte_o);
            end else if (burst.size() > 0) begin
                got_len.push_back(burst.size());
                foreach (burst[i]) got_bytes.push_back(burst[i]);
                burst.delete();
            end
        end
    end

    // compare against reference
    initial begin
        int n;
        forever begin
            @(negedge clock_camera_byte);
            if (got_len.size() > 0) begin
                n = got_len.pop_front();
                cur_pkt.delete();
                repeat (n) cur_pkt.push_back(got_bytes.pop_front());
                packets_seen++;
                if (exp_len.size() == 0) begin
                    errors++;
                    $display("unexpected packet of %0d bytes on the lane", n);
                end else begin
                    compare_burst();
                end
            end
        end
    end

    initial begin
        reset_camera_byte_n = 1'b0;
        pixel_valid_i       = 1'b0;
        frame_valid_i       = 1'b0;
        line_valid_i        = 1'b0;
        pixel_i             = '0;
        hs_rdy_i            = 1'b0;
        repeat (8) @(negedge clock_camera_byte);
        reset_camera_byte_n = 1'b1;
        repeat (4) @(negedge clock_camera_byte);

        // frames 1 to 3, four random lines each
        for (int f = 0; f < 3; f++) drive_frame(4, 0, "frame_sequence");
        wait_drained("frame sequence packets");

        drive_frame(1, 1, "raw10_packing");
        wait_drained("raw10 packing packets");

        slow_phy = 1'b1;
        for (int f = 0; f < 2; f++) drive_frame(4, 0, "slow_phy");
        wait_drained("slow phy packets");
        check_value("overflow", 0, overflow_o);

        finish_run();
    end

endmodule

// ==== sources.f ====
logic/csi2_pkg.sv
logic/raw10_byte_packer.sv
logic/event_queue.sv
logic/csi2_packet_builder.sv
logic/hs_lane_ctrl.sv
logic/csi2_tx_top.sv
sim/csi2_tx_sva.sv
sim/csi2_tx_tb.sv

// ==== Bender.yml ====
package:
  name: csi2_tx

sources:
  - logic/csi2_pkg.sv
  - logic/raw10_byte_packer.sv
  - logic/event_queue.sv
  - logic/csi2_packet_builder.sv
  - logic/hs_lane_ctrl.sv
  - logic/csi2_tx_top.sv
  - target: simulation
    files:
      - sim/csi2_tx_sva.sv
      - sim/csi2_tx_tb.sv
